// ==== hw/peak_alu.sv ====
`timescale 1ns/1ps

module peak_alu (
  input  peak_pkg::dec_s  dec,
  input  peak_pkg::word_t rs1_val,
  input  peak_pkg::word_t rs2_val,
  input  peak_pkg::word_t pc,
  output peak_pkg::word_t result,
  output peak_pkg::word_t sum,
  output logic            taken
);

  peak_pkg::word_t op_b;
  peak_pkg::word_t base;
  peak_pkg::word_t target;
  logic [4:0]      shamt;
  logic            cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      peak_pkg::ALU_SUB:  result = rs1_val - op_b;
      peak_pkg::ALU_SLL:  result = rs1_val << shamt;
      peak_pkg::ALU_SLT:  result = {31'd0, $signed(rs1_val) < $signed(op_b)};
      peak_pkg::ALU_SLTU: result = {31'd0, rs1_val < op_b};
      peak_pkg::ALU_XOR:  result = rs1_val ^ op_b;
      peak_pkg::ALU_SRL:  result = rs1_val >> shamt;
      peak_pkg::ALU_SRA:  result = $signed(rs1_val) >>> shamt;
      peak_pkg::ALU_OR:   result = rs1_val | op_b;
      peak_pkg::ALU_AND:  result = rs1_val & op_b;
      default:            result = rs1_val + op_b;
    endcase
  end

  // Address and target adder
  assign base   = (dec.load | dec.store | dec.jalr) ? rs1_val : pc;
  assign target = base + dec.imm;
  // JALR drops bit 0 of the target
  assign sum    = {target[31:1], target[0] & ~dec.jalr};

  always_comb begin
    case (dec.funct3[2:1])
      2'b00:   cond = (rs1_val == rs2_val);
      2'b10:   cond = $signed(rs1_val) < $signed(rs2_val);
      2'b11:   cond = rs1_val < rs2_val;
      default: cond = 1'b0;
    endcase
  end

  // funct3[0] inverts the compare (BNE, BGE, BGEU)
  assign taken = (dec.branch & (cond ^ dec.funct3[0])) | dec.jal | dec.jalr;

endmodule

// ==== hw/peak_core.sv ====
`timescale 1ns/1ps

module peak_core #(
  parameter peak_pkg::word_t START_ADDR = 32'h0000_0000
) (
  input  logic                 CLK,
  input  logic                 RST_N,
  // Instruction side
  output peak_pkg::fetch_req_s fetch_req,
  input  peak_pkg::mem_rsp_s   fetch_rsp,
  // Data side
  output peak_pkg::mem_req_s   data_req,
  input  peak_pkg::mem_rsp_s   data_rsp,
  // Run control
  input  logic                 halt_req,
  input  logic                 resume_req,
  output logic                 halted,
  output logic                 resuming,
  output logic                 running,
  // Debug
  input  peak_pkg::dbg_req_s   dbg_req,
  output peak_pkg::word_t      dbg_rdata
);

  peak_pkg::dec_s  dec;
  peak_pkg::word_t rs1_val;
  peak_pkg::word_t rs2_val;
  peak_pkg::word_t result;
  peak_pkg::word_t sum;
  peak_pkg::word_t load_val;
  peak_pkg::word_t rd_val;
  logic            taken;
  logic            active;
  logic            we;

  //////////////////////////////////////////////////////////////////////
  // Decode and execute
  //////////////////////////////////////////////////////////////////////
  peak_decode u_decode (
    .inst (fetch_rsp.rdata),
    .dec  (dec)
  );

  peak_alu u_alu (
    .dec     (dec),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .pc      (fetch_req.addr),
    .result  (result),
    .sum     (sum),
    .taken   (taken)
  );

  peak_lsu u_lsu (
    .dec      (dec),
    .active   (active),
    .addr     (sum),
    .rs2_val  (rs2_val),
    .data_req (data_req),
    .data_rsp (data_rsp),
    .load_val (load_val)
  );

  //////////////////////////////////////////////////////////////////////
  // Registers and control
  //////////////////////////////////////////////////////////////////////
  peak_regfile u_regfile (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .rs1       (dec.rs1),
    .rs2       (dec.rs2),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .we        (we),
    .rd        (dec.rd),
    .rd_val    (rd_val),
    .halted    (halted),
    .dbg_req   (dbg_req),
    .dbg_rdata (dbg_rdata)
  );

  peak_sequencer #(
    .START_ADDR (START_ADDR)
  ) u_sequencer (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .fetch_req  (fetch_req),
    .fetch_rsp  (fetch_rsp),
    .dec        (dec),
    .taken      (taken),
    .sum        (sum),
    .result     (result),
    .load_val   (load_val),
    .data_done  (data_rsp.ready),
    .halt_req   (halt_req),
    .resume_req (resume_req),
    .active     (active),
    .halted     (halted),
    .resuming   (resuming),
    .running    (running),
    .we         (we),
    .rd_val     (rd_val)
  );

endmodule

// ==== hw/peak_decode.sv ====
`timescale 1ns/1ps

module peak_decode (
  input  peak_pkg::inst_u inst,
  output peak_pkg::dec_s  dec
);

  logic [6:0]        funct7;
  logic [2:0]        funct3;
  logic              alt;
  logic              imm_ok;
  logic              reg_ok;
  peak_pkg::alu_op_e op;
  peak_pkg::word_t   i_imm;
  peak_pkg::word_t   s_imm;
  peak_pkg::word_t   b_imm;
  peak_pkg::word_t   u_imm;
  peak_pkg::word_t   j_imm;

  assign funct7 = inst.r_fmt.funct7;
  assign funct3 = inst.r_fmt.funct3;
  assign alt    = funct7[5];

  // Shift immediates only allow funct7 of 0, or 0x20 for SRAI
  assign imm_ok = (funct3[1:0] != 2'b01) | (funct7 == 7'h00) | ((funct7 == 7'h20) & funct3[2]);
  // SUB and SRA are the only register ops with funct7 0x20
  assign reg_ok = (funct7 == 7'h00) |
                  ((funct7 == 7'h20) & ((funct3 == 3'b000) | (funct3 == 3'b101)));

  //////////////////////////////////////////////////////////////////////
  // Immediates, one per format view
  //////////////////////////////////////////////////////////////////////
  assign i_imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign s_imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign b_imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                  inst.b_fmt.imm_4_1, 1'b0};
  assign u_imm = {inst.u_fmt.imm_31_12, 12'h000};
  assign j_imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                  inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  op = peak_pkg::ALU_ADD;
      3'b001:  op = peak_pkg::ALU_SLL;
      3'b010:  op = peak_pkg::ALU_SLT;
      3'b011:  op = peak_pkg::ALU_SLTU;
      3'b100:  op = peak_pkg::ALU_XOR;
      3'b101:  op = alt ? peak_pkg::ALU_SRA : peak_pkg::ALU_SRL;
      3'b110:  op = peak_pkg::ALU_OR;
      default: op = peak_pkg::ALU_AND;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Class decode
  //////////////////////////////////////////////////////////////////////
  // Anything not matched keeps rd at x0 and no class bit, so it acts as NOP
  always_comb begin
    dec        = '0;
    dec.funct3 = funct3;
    dec.alu_op = op;
    case (inst.r_fmt.opcode)
      peak_pkg::OPC_LUI: begin
        dec.lui = 1'b1;
        dec.rd  = inst.u_fmt.rd;
        dec.imm = u_imm;
      end
      peak_pkg::OPC_AUIPC: begin
        dec.auipc = 1'b1;
        dec.rd    = inst.u_fmt.rd;
        dec.imm   = u_imm;
      end
      peak_pkg::OPC_JAL: begin
        dec.jal = 1'b1;
        dec.rd  = inst.j_fmt.rd;
        dec.imm = j_imm;
      end
      peak_pkg::OPC_JALR: begin
        dec.jalr = (funct3 == 3'b000);
        dec.rd   = dec.jalr ? inst.i_fmt.rd : 5'd0;
        dec.rs1  = inst.i_fmt.rs1;
        dec.imm  = i_imm;
      end
      peak_pkg::OPC_BRANCH: begin
        dec.branch = (funct3[2:1] != 2'b01);
        dec.rs1    = inst.b_fmt.rs1;
        dec.rs2    = inst.b_fmt.rs2;
        dec.imm    = b_imm;
      end
      peak_pkg::OPC_LOAD: begin
        dec.load = (funct3 != 3'b011) & (funct3[2:1] != 2'b11);
        dec.rd   = dec.load ? inst.i_fmt.rd : 5'd0;
        dec.rs1  = inst.i_fmt.rs1;
        dec.imm  = i_imm;
      end
      peak_pkg::OPC_STORE: begin
        dec.store = ~funct3[2] & (funct3[1:0] != 2'b11);
        dec.rs1   = inst.s_fmt.rs1;
        dec.rs2   = inst.s_fmt.rs2;
        dec.imm   = s_imm;
      end
      peak_pkg::OPC_OP_IMM: begin
        dec.use_imm = imm_ok;
        dec.rd      = imm_ok ? inst.i_fmt.rd : 5'd0;
        dec.rs1     = inst.i_fmt.rs1;
        dec.imm     = i_imm;
      end
      peak_pkg::OPC_OP: begin
        dec.rd  = reg_ok ? inst.r_fmt.rd : 5'd0;
        dec.rs1 = inst.r_fmt.rs1;
        dec.rs2 = inst.r_fmt.rs2;
        if ((funct3 == 3'b000) && alt) begin
          dec.alu_op = peak_pkg::ALU_SUB;
        end
      end
      peak_pkg::OPC_SYSTEM: begin
        dec.ebreak = (inst == 32'h0010_0073);
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hw/peak_lsu.sv ====
`timescale 1ns/1ps

module peak_lsu (
  input  peak_pkg::dec_s     dec,
  input  logic               active,
  input  peak_pkg::word_t    addr,
  input  peak_pkg::word_t    rs2_val,
  output peak_pkg::mem_req_s data_req,
  input  peak_pkg::mem_rsp_s data_rsp,
  output peak_pkg::word_t    load_val
);

  logic [1:0]      size;
  logic [1:0]      lane;
  peak_pkg::word_t shifted;

  assign size = dec.funct3[1:0];
  assign lane = addr[1:0];

  // Store lane steering
  always_comb begin
    data_req.valid = active & (dec.load | dec.store);
    data_req.addr  = addr;
    case (size)
      2'b00: begin
        data_req.wdata = {4{rs2_val[7:0]}};
        data_req.wstb  = 4'b0001 << lane;
      end
      2'b01: begin
        data_req.wdata = {2{rs2_val[15:0]}};
        data_req.wstb  = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data_req.wdata = rs2_val;
        data_req.wstb  = 4'b1111;
      end
    endcase
    // Loads are reads, no strobes
    if (!dec.store) begin
      data_req.wstb = 4'b0000;
    end
  end

  // Load lane select and extension, funct3[2] marks unsigned
  assign shifted = data_rsp.rdata >> {lane, 3'b000};

  always_comb begin
    case (size)
      2'b00:   load_val = {{24{shifted[7] & ~dec.funct3[2]}}, shifted[7:0]};
      2'b01:   load_val = {{16{shifted[15] & ~dec.funct3[2]}}, shifted[15:0]};
      default: load_val = data_rsp.rdata;
    endcase
  end

endmodule

// ==== hw/peak_pkg.sv ====
package peak_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_num_t;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Debug page of the general registers
  localparam logic [7:0] DBG_REG_PAGE = 8'h10;

  //////////////////////////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    reg_num_t   rs2;
    reg_num_t   rs1;
    logic [2:0] funct3;
    reg_num_t   rd;
    logic [6:0] opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_num_t    rs1;
    logic [2:0]  funct3;
    reg_num_t    rd;
    logic [6:0]  opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_num_t   rs2;
    reg_num_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_s;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_num_t   rs2;
    reg_num_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_s;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_num_t    rd;
    logic [6:0]  opcode;
  } u_fmt_s;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_num_t   rd;
    logic [6:0] opcode;
  } j_fmt_s;

  typedef union packed {
    r_fmt_s r_fmt;
    i_fmt_s i_fmt;
    s_fmt_s s_fmt;
    b_fmt_s b_fmt;
    u_fmt_s u_fmt;
    j_fmt_s j_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Decoded instruction and bus bundles
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    reg_num_t   rd;
    reg_num_t   rs1;
    reg_num_t   rs2;
    word_t      imm;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    logic       use_imm;
    logic       lui;
    logic       auipc;
    logic       jal;
    logic       jalr;
    logic       branch;
    logic       load;
    logic       store;
    logic       ebreak;
  } dec_s;

  typedef struct packed {
    logic  valid;
    word_t addr;
  } fetch_req_s;

  typedef struct packed {
    logic       valid;
    logic [3:0] wstb;
    word_t      addr;
    word_t      wdata;
  } mem_req_s;

  typedef struct packed {
    logic  ready;
    word_t rdata;
    logic  spare;
  } mem_rsp_s;

  typedef struct packed {
    logic        en;
    logic        wr;
    logic [15:0] addr;
    word_t       wdata;
  } dbg_req_s;

endpackage

// ==== hw/peak_regfile.sv ====
`timescale 1ns/1ps

module peak_regfile (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  peak_pkg::reg_num_t   rs1,
  input  peak_pkg::reg_num_t   rs2,
  output peak_pkg::word_t      rs1_val,
  output peak_pkg::word_t      rs2_val,
  input  logic                 we,
  input  peak_pkg::reg_num_t   rd,
  input  peak_pkg::word_t      rd_val,
  input  logic                 halted,
  input  peak_pkg::dbg_req_s   dbg_req,
  output peak_pkg::word_t      dbg_rdata
);

  peak_pkg::word_t    regs [1:31];
  logic               dbg_hit;
  logic               dbg_wr;
  peak_pkg::reg_num_t dbg_num;

  // Debug page decode, only while halted
  assign dbg_hit = dbg_req.en & halted & (dbg_req.addr[15:8] == peak_pkg::DBG_REG_PAGE);
  assign dbg_wr  = dbg_hit & dbg_req.wr;
  assign dbg_num = dbg_req.addr[4:0];

  always_ff @(posedge CLK) begin
    if (we && (rd != 5'd0)) begin
      regs[rd] <= rd_val;
    end else if (dbg_wr && (dbg_num != 5'd0)) begin
      regs[dbg_num] <= dbg_req.wdata;
    end
  end

  // x0 is hardwired
  assign rs1_val   = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_val   = (rs2 == 5'd0) ? '0 : regs[rs2];
  assign dbg_rdata = (dbg_hit && (dbg_num != 5'd0)) ? regs[dbg_num] : '0;

  // Retire writes only happen while running, debug writes only while halted
  assert property (@(posedge CLK) disable iff (!RST_N) !(we && dbg_wr));

endmodule

// ==== hw/peak_sequencer.sv ====
`timescale 1ns/1ps

module peak_sequencer #(
  parameter peak_pkg::word_t START_ADDR = 32'h0000_0000
) (
  input  logic                 CLK,
  input  logic                 RST_N,
  output peak_pkg::fetch_req_s fetch_req,
  input  peak_pkg::mem_rsp_s   fetch_rsp,
  input  peak_pkg::dec_s       dec,
  input  logic                 taken,
  input  peak_pkg::word_t      sum,
  input  peak_pkg::word_t      result,
  input  peak_pkg::word_t      load_val,
  input  logic                 data_done,
  input  logic                 halt_req,
  input  logic                 resume_req,
  output logic                 active,
  output logic                 halted,
  output logic                 resuming,
  output logic                 running,
  output logic                 we,
  output peak_pkg::word_t      rd_val
);

  typedef enum logic [1:0] {
    S_RESET,
    S_EXEC,
    S_HALT,
    S_RESUME
  } state_e;

  state_e          state;
  peak_pkg::word_t pc;
  peak_pkg::word_t pc_inc;
  logic            halt_req_q;
  logic            retire;

  assign pc_inc   = pc + 32'd4;
  assign active   = (state == S_EXEC);
  assign halted   = (state == S_HALT);
  assign resuming = (state == S_RESUME);
  assign running  = (state == S_RESET) | active;

  assign fetch_req.valid = active;
  assign fetch_req.addr  = pc;

  // Loads and stores also wait for the data side
  assign retire = active & fetch_rsp.ready & (~(dec.load | dec.store) | data_done);
  assign we     = retire & ~dec.ebreak;

  always_comb begin
    if (dec.load) begin
      rd_val = load_val;
    end else if (dec.lui) begin
      rd_val = dec.imm;
    end else if (dec.auipc) begin
      rd_val = sum;
    end else if (dec.jal | dec.jalr) begin
      rd_val = pc_inc;
    end else begin
      rd_val = result;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      halt_req_q <= 1'b0;
    end else begin
      halt_req_q <= halt_req;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Run/halt FSM and PC
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= S_RESET;
      pc    <= START_ADDR;
    end else begin
      if (retire) begin
        pc <= taken ? sum : pc_inc;
      end
      case (state)
        S_RESET:  state <= halt_req_q ? S_HALT : S_EXEC;
        S_EXEC: begin
          // EBREAK halts with pc already on the next instruction
          if (retire && (halt_req_q || dec.ebreak)) begin
            state <= S_HALT;
          end
        end
        S_HALT: begin
          if (resume_req) begin
            state <= S_RESUME;
          end
        end
        S_RESUME: begin
          if (!resume_req) begin
            state <= S_RESET;
          end
        end
        default:  state <= S_RESET;
      endcase
    end
  end

  // A fetch held off by the memory keeps its address
  assert property (@(posedge CLK) disable iff (!RST_N)
    fetch_req.valid && !fetch_rsp.ready |=> fetch_req.valid && $stable(fetch_req.addr));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the peak core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_peak -o sim_peak; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_peak > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
exit 1

// ==== test/tb_peak_model.svh ====
`ifndef TB_PEAK_MODEL_SVH
`define TB_PEAK_MODEL_SVH

integer                  seed;
peak_pkg::word_t         prog [0:255];
peak_pkg::word_t         m_regs [0:31];
peak_pkg::word_t         m_mem [0:63];
peak_pkg::mem_req_s      exp_stores [$];
int                      ebreak_idx;

localparam peak_pkg::word_t NOP_WORD    = 32'h0000_0013;
localparam peak_pkg::word_t EBREAK_WORD = 32'h0010_0073;
localparam peak_pkg::word_t DATA_BASE   = 32'h0000_2000;

function automatic int rnd(int n);
  return ($random(seed) & 32'h7fff_ffff) % n;
endfunction

// Initial memory contents, a hash of the full byte address
function automatic peak_pkg::word_t fill_word(peak_pkg::word_t a);
  return (a * 32'h9e37_79b1) ^ 32'h1234_5678;
endfunction

function automatic peak_pkg::word_t sext12(logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

function automatic peak_pkg::word_t enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] opc);
  return {imm, 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic peak_pkg::word_t enc_r(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
  return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), peak_pkg::OPC_OP};
endfunction

function automatic peak_pkg::word_t enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
  return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], peak_pkg::OPC_STORE};
endfunction

function automatic peak_pkg::word_t enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
  return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11],
          peak_pkg::OPC_BRANCH};
endfunction

function automatic peak_pkg::word_t enc_j(logic [20:0] imm, int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), peak_pkg::OPC_JAL};
endfunction

// RV32I integer ops by funct3, alt selects SUB and SRA
function automatic peak_pkg::word_t alu_model(int f3, logic alt, peak_pkg::word_t a,
                                              peak_pkg::word_t b);
  case (f3)
    0: return alt ? a - b : a + b;
    1: return a << b[4:0];
    2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3: return (a < b) ? 32'd1 : 32'd0;
    4: return a ^ b;
    5: return alt ? peak_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_model(int f3, peak_pkg::word_t a, peak_pkg::word_t b);
  case (f3)
    0: return a == b;
    1: return a != b;
    4: return $signed(a) < $signed(b);
    5: return $signed(a) >= $signed(b);
    6: return a < b;
    default: return a >= b;
  endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Program generator, executed on the model as it is built
//////////////////////////////////////////////////////////////////////
task automatic build_program(peak_pkg::word_t start);
  int                 idx;
  int                 k;
  int                 f3;
  int                 rd;
  int                 rs1;
  int                 rs2;
  int                 step;
  logic               alt;
  logic [11:0]        i12;
  logic [19:0]        u20;
  logic [7:0]         off;
  peak_pkg::word_t    pc;
  peak_pkg::word_t    w;
  peak_pkg::mem_req_s st;
  for (int i = 0; i < 256; i++) begin
    prog[i] = NOP_WORD;
  end
  for (int i = 0; i < 64; i++) begin
    m_mem[i] = fill_word(DATA_BASE + 32'(4 * i));
  end
  // x31 holds the data window base, x1..x30 get random values
  prog[0] = {20'h00002, 5'd31, peak_pkg::OPC_LUI};
  m_regs[0] = '0;
  m_regs[31] = DATA_BASE;
  for (int r = 1; r <= 30; r++) begin
    u20 = 20'($random(seed));
    i12 = 12'($random(seed));
    prog[2 * r - 1] = {u20, 5'(r), peak_pkg::OPC_LUI};
    prog[2 * r] = enc_i(i12, r, 0, r, peak_pkg::OPC_OP_IMM);
    m_regs[r] = {u20, 12'h000} + sext12(i12);
  end
  idx = 61;
  ebreak_idx = 121;
  while (idx < ebreak_idx) begin
    pc = start + 32'(4 * idx);
    rd = 1 + rnd(30);
    rs1 = rnd(32);
    rs2 = rnd(32);
    step = 1;
    k = rnd(3);
    if (k > ebreak_idx - idx - 1) begin
      k = ebreak_idx - idx - 1;
    end
    case (rnd(8))
      0: begin
        f3 = rnd(8);
        i12 = 12'(rnd(4096));
        alt = 1'b0;
        if (f3 == 1) begin
          i12 = {7'h00, i12[4:0]};
        end else if (f3 == 5) begin
          alt = rnd(2) == 1;
          i12 = {alt ? 7'h20 : 7'h00, i12[4:0]};
        end
        prog[idx] = enc_i(i12, rs1, f3, rd, peak_pkg::OPC_OP_IMM);
        m_regs[rd] = alu_model(f3, alt, m_regs[rs1], sext12(i12));
      end
      1: begin
        f3 = rnd(8);
        alt = ((f3 == 0) || (f3 == 5)) && (rnd(2) == 1);
        prog[idx] = enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        m_regs[rd] = alu_model(f3, alt, m_regs[rs1], m_regs[rs2]);
      end
      2: begin
        u20 = 20'($random(seed));
        prog[idx] = {u20, 5'(rd), peak_pkg::OPC_LUI};
        m_regs[rd] = {u20, 12'h000};
      end
      3: begin
        u20 = 20'($random(seed));
        prog[idx] = {u20, 5'(rd), peak_pkg::OPC_AUIPC};
        m_regs[rd] = pc + {u20, 12'h000};
      end
      4: begin
        case (rnd(5))
          0: f3 = 0;
          1: f3 = 1;
          2: f3 = 2;
          3: f3 = 4;
          default: f3 = 5;
        endcase
        off = 8'(rnd(256));
        off = (f3[1:0] == 2'b00) ? off : (f3[1:0] == 2'b01) ? {off[7:1], 1'b0} :
              {off[7:2], 2'b00};
        prog[idx] = enc_i({4'h0, off}, 31, f3, rd, peak_pkg::OPC_LOAD);
        w = m_mem[off[7:2]] >> (8 * off[1:0]);
        case (f3)
          0: m_regs[rd] = {{24{w[7]}}, w[7:0]};
          1: m_regs[rd] = {{16{w[15]}}, w[15:0]};
          4: m_regs[rd] = {24'd0, w[7:0]};
          5: m_regs[rd] = {16'd0, w[15:0]};
          default: m_regs[rd] = w;
        endcase
      end
      5: begin
        f3 = rnd(3);
        off = 8'(rnd(256));
        st.valid = 1'b1;
        if (f3 == 0) begin
          st.wstb = 4'b0001 << off[1:0];
          st.wdata = {4{m_regs[rs2][7:0]}};
        end else if (f3 == 1) begin
          off[0] = 1'b0;
          st.wstb = off[1] ? 4'b1100 : 4'b0011;
          st.wdata = {2{m_regs[rs2][15:0]}};
        end else begin
          off[1:0] = 2'b00;
          st.wstb = 4'b1111;
          st.wdata = m_regs[rs2];
        end
        st.addr = DATA_BASE + {24'd0, off};
        prog[idx] = enc_s({4'h0, off}, rs2, 31, f3);
        for (int b = 0; b < 4; b++) begin
          if (st.wstb[b]) begin
            m_mem[off[7:2]][8 * b +: 8] = st.wdata[8 * b +: 8];
          end
        end
        exp_stores.push_back(st);
      end
      6: begin
        case (rnd(6))
          0: f3 = 0;
          1: f3 = 1;
          2: f3 = 4;
          3: f3 = 5;
          4: f3 = 6;
          default: f3 = 7;
        endcase
        prog[idx] = enc_b(13'(4 * (k + 1)), rs2, rs1, f3);
        if (branch_model(f3, m_regs[rs1], m_regs[rs2])) begin
          step = k + 1;
        end
      end
      default: begin
        prog[idx] = enc_j(21'(4 * (k + 1)), rd);
        m_regs[rd] = pc + 32'd4;
        step = k + 1;
      end
    endcase
    // Skipped slots hold filler that must never execute
    for (int j = 1; j < step; j++) begin
      prog[idx + j] = enc_i(12'(rnd(4096)), rnd(32), 0, 1 + rnd(30), peak_pkg::OPC_OP_IMM);
    end
    idx = idx + step;
  end
  prog[ebreak_idx] = EBREAK_WORD;
  prog[ebreak_idx + 1] = EBREAK_WORD;
endtask

`endif

// ==== test/tb_peak.sv ====
`timescale 1ns/1ps

module tb_peak;

  localparam peak_pkg::word_t START_ADDR = 32'h0000_0100;

  logic                 CLK;
  logic                 RST_N;
  peak_pkg::fetch_req_s fetch_req;
  peak_pkg::mem_rsp_s   fetch_rsp;
  peak_pkg::mem_req_s   data_req;
  peak_pkg::mem_rsp_s   data_rsp;
  logic                 halt_req;
  logic                 resume_req;
  logic                 halted;
  logic                 resuming;
  logic                 running;
  peak_pkg::dbg_req_s   dbg_req;
  peak_pkg::word_t      dbg_rdata;

  peak_pkg::word_t      dmem [0:63];
  int                   word_errs;
  int                   store_errs;
  int                   bit_errs;
  int                   other_errs;

  `include "tb_peak_model.svh"

  peak_core #(
    .START_ADDR (START_ADDR)
  ) dut0 (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .fetch_req  (fetch_req),
    .fetch_rsp  (fetch_rsp),
    .data_req   (data_req),
    .data_rsp   (data_rsp),
    .halt_req   (halt_req),
    .resume_req (resume_req),
    .halted     (halted),
    .resuming   (resuming),
    .running    (running),
    .dbg_req    (dbg_req),
    .dbg_rdata  (dbg_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////
  task automatic check_word(string name, peak_pkg::word_t exp, peak_pkg::word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_store(string name, peak_pkg::mem_req_s exp, peak_pkg::mem_req_s act);
    if (act !== exp) begin
      store_errs++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  function automatic peak_pkg::word_t fetch_word(peak_pkg::word_t addr);
    peak_pkg::word_t idx;
    idx = (addr - START_ADDR) >> 2;
    if ((addr < START_ADDR) || (idx > 255)) begin
      return NOP_WORD;
    end
    return prog[idx[7:0]];
  endfunction

  // Both buses with random ready
  // Data ready only comes alongside fetch ready
  always @(negedge CLK) begin
    peak_pkg::word_t    off;
    peak_pkg::mem_req_s exp;
    fetch_rsp.ready = (($random(seed) & 3) != 0);
    fetch_rsp.rdata = fetch_word(fetch_req.addr);
    #1;
    data_rsp.ready = 1'b0;
    if (data_req.valid) begin
      off = data_req.addr - DATA_BASE;
      if (off >= 256) begin
        other_errs++;
        $display("data access outside the data window at %h", data_req.addr);
      end else begin
        data_rsp.rdata = dmem[off[7:2]];
        data_rsp.ready = fetch_rsp.ready && (($random(seed) & 1) != 0);
        if (data_rsp.ready && (data_req.wstb != 4'b0000)) begin
          if (exp_stores.size() == 0) begin
            other_errs++;
            $display("unexpected store to %h", data_req.addr);
          end else begin
            exp = exp_stores.pop_front();
            check_store("store", exp, data_req);
          end
          for (int b = 0; b < 4; b++) begin
            if (data_req.wstb[b]) begin
              dmem[off[7:2]][8 * b +: 8] = data_req.wdata[8 * b +: 8];
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Waits and debug access
  ////////////////////////////////////////////////////////////////////
  task automatic wait_halt(int limit);
    int n;
    n = 0;
    while (!halted && (n < limit)) begin
      @(negedge CLK);
      n++;
    end
    if (!halted) begin
      other_errs++;
      $display("timeout while waiting for the core to halt");
    end
  endtask

  task automatic wait_fetch(int limit);
    int n;
    n = 0;
    while (!fetch_req.valid && (n < limit)) begin
      @(negedge CLK);
      n++;
    end
    if (!fetch_req.valid) begin
      other_errs++;
      $display("timeout while waiting for a fetch request");
    end
  endtask

  task automatic resume_pulse();
    int n;
    @(negedge CLK);
    resume_req = 1'b1;
    n = 0;
    while (!resuming && (n < 20)) begin
      @(negedge CLK);
      n++;
    end
    check_bit("resuming_high", 1'b1, resuming);
    repeat (2) @(negedge CLK);
    check_bit("resuming_held", 1'b1, resuming);
    resume_req = 1'b0;
    @(negedge CLK);
    check_bit("resuming_low", 1'b0, resuming);
    check_bit("running_after_resume", 1'b1, running);
  endtask

  task automatic read_reg(int r, output peak_pkg::word_t val);
    @(negedge CLK);
    dbg_req = '{en: 1'b1, wr: 1'b0, addr: {peak_pkg::DBG_REG_PAGE, 3'd0, 5'(r)}, wdata: '0};
    #1;
    val = dbg_rdata;
    dbg_req.en = 1'b0;
  endtask

  task automatic write_reg(int r, peak_pkg::word_t val);
    @(negedge CLK);
    dbg_req = '{en: 1'b1, wr: 1'b1, addr: {peak_pkg::DBG_REG_PAGE, 3'd0, 5'(r)}, wdata: val};
    @(negedge CLK);
    dbg_req = '0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    peak_pkg::word_t val;
    RST_N = 1'b0;
    fetch_rsp = '0;
    data_rsp = '0;
    halt_req = 1'b0;
    resume_req = 1'b0;
    dbg_req = '0;
    word_errs = 0;
    store_errs = 0;
    bit_errs = 0;
    other_errs = 0;
    seed = 32'h7524_6b8b;
    build_program(START_ADDR);
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(DATA_BASE + 32'(4 * i));
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST_N = 1'b1;
    check_bit("reset_halted", 1'b0, halted);
    check_bit("reset_resuming", 1'b0, resuming);
    check_bit("reset_running", 1'b1, running);
    check_bit("reset_fetch_valid", 1'b0, fetch_req.valid);
    check_bit("reset_data_valid", 1'b0, data_req.valid);
    wait_fetch(20);
    check_word("first_fetch", START_ADDR, fetch_req.addr);

    // Halt in the middle of the register setup
    repeat (40) @(negedge CLK);
    halt_req = 1'b1;
    wait_halt(50);
    halt_req = 1'b0;
    check_bit("halt_running", 1'b0, running);
    check_bit("halt_fetch_valid", 1'b0, fetch_req.valid);
    check_bit("halt_data_valid", 1'b0, data_req.valid);
    resume_pulse();

    wait_halt(3000);
    for (int r = 1; r < 32; r++) begin
      read_reg(r, val);
      check_word($sformatf("x%0d", r), m_regs[r], val);
    end
    write_reg(5, 32'hcafe_0505);
    read_reg(5, val);
    check_word("dbg_x5", 32'hcafe_0505, val);

    // Continue after the EBREAK
    resume_pulse();
    wait_fetch(20);
    check_word("fetch_after_ebreak", START_ADDR + 32'(4 * (ebreak_idx + 1)), fetch_req.addr);
    wait_halt(50);
    read_reg(5, val);
    check_word("x5_after_resume", 32'hcafe_0505, val);
    if (exp_stores.size() != 0) begin
      other_errs++;
      $display("%0d expected stores never appeared", exp_stores.size());
    end

    $display("errors: word %0d store %0d bit %0d other %0d",
             word_errs, store_errs, bit_errs, other_errs);
    if ((word_errs + store_errs + bit_errs + other_errs) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+test
hw/peak_pkg.sv
hw/peak_decode.sv
hw/peak_alu.sv
hw/peak_regfile.sv
hw/peak_lsu.sv
hw/peak_sequencer.sv
hw/peak_core.sv
test/tb_peak.sv
